//--- tb.f
hdl/aluPkg.sv
hdl/lookaheadAdder.sv
hdl/barrelShifter.sv
hdl/sliceComparator.sv
hdl/aluCore.sv
hdl/stageLatch.sv
hdl/aluStage.sv
test/tbClock.sv
test/aluStage_properties.sv
test/aluStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module aluStageTb -o simAluStage
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simAluStage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

//--- test/aluStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module aluStageTb import aluPkg::*; ();

	localparam int clkPeriod = 20;
	localparam int resetCycles = 10;
	localparam int driveDelay = 2;
	localparam int testCycles = 12 + 400 + 100 + 128 + 55 + 34;
	localparam int marginCycles = 100;

	logic clk;
	logic arstN;
	word_t opA;
	word_t opB;
	aluOp_t aluOp;
	shamt_t shiftAmt;
	logic we;
	logic flush;
	word_t result;
	logic neq;
	logic lt;

	logic [31:0] rngState = 32'hf517_f299;
	int checkCount = 0;
	int errorCount = 0;
	int testChecks = 0;
	int testErrors = 0;
	word_t expResult = '0; // latch model.
	logic expNeq = 1'b0;
	logic expLt = 1'b0;

	tbClock #(
		.periodNs(clkPeriod),
		.resetCycles(resetCycles)
	) clock_i (
		.clk(clk),
		.arstN(arstN)
	);

	aluStage #(
		.dataWidth(wordWidth)
	) dut_i (
		.clk(clk),
		.arstN(arstN),
		.opA(opA),
		.opB(opB),
		.aluOp(aluOp),
		.shiftAmt(shiftAmt),
		.we(we),
		.flush(flush),
		.result(result),
		.neq(neq),
		.lt(lt)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic word_t modelResult(input aluOp_t op, input word_t a, input word_t b,
			input shamt_t sh);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opSll: return a << sh;
			opSra: return word_t'($signed(a) >>> sh);
			default: return '0;
		endcase
	endfunction

	task automatic checkOutputs(input string name);
		checkCount++;
		assert (result === expResult) else begin
			$display("FAIL %s: result expected %h, actual %h", name, expResult, result);
			errorCount++;
		end
		assert ({neq, lt} === {expNeq, expLt}) else begin
			$display("FAIL %s: neq,lt expected %b%b, actual %b%b", name, expNeq, expLt,
				neq, lt);
			errorCount++;
		end
	endtask

	// drives one cycle, advances the model, checks after the edge.
	task automatic runCycle(input string name, input logic weIn, input logic flushIn,
			input aluOp_t op, input word_t a, input word_t b, input shamt_t sh);
		we = weIn;
		flush = flushIn;
		aluOp = op;
		opA = a;
		opB = b;
		shiftAmt = sh;
		if (flushIn) begin
			expResult = '0;
			expNeq = 1'b0;
			expLt = 1'b0;
		end else if (weIn) begin
			expResult = modelResult(op, a, b, sh);
			expNeq = (a != b);
			expLt = (a < b); // unsigned.
		end
		@(posedge clk);
		#driveDelay;
		checkOutputs(name);
	endtask

	task automatic startTest();
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		$display("%s done: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
	endtask

	initial begin
		word_t a;
		word_t b;
		word_t d;
		opA = 32'h1234_5678; // nonzero so a load without we shows.
		opB = 32'h0f0f_0f0f;
		aluOp = opOr;
		shiftAmt = '0;
		we = 1'b0;
		flush = 1'b0;

		startTest();
		@(posedge clk);
		@(negedge clk);
		while (!arstN) begin
			checkOutputs("reset");
			@(negedge clk);
		end
		checkOutputs("reset"); // released but nothing loaded yet.
		@(posedge clk);
		#driveDelay;
		checkOutputs("reset");
		endTest("reset");

		startTest();
		repeat (200) begin
			a = randWord();
			b = randWord();
			runCycle("addSub", 1'b1, 1'b0, opAdd, a, b, '0);
			runCycle("addSub", 1'b1, 1'b0, opSub, a, b, '0);
		end
		endTest("addSub");

		startTest();
		repeat (50) begin
			a = randWord();
			b = randWord();
			runCycle("andOr", 1'b1, 1'b0, opAnd, a, b, '0);
			runCycle("andOr", 1'b1, 1'b0, opOr, a, b, '0);
		end
		endTest("andOr");

		// each amount once with any sign and once negative.
		startTest();
		for (int i = 0; i < 64; i++) begin
			d = randWord();
			if (i >= 32) d[31] = 1'b1;
			runCycle("shift", 1'b1, 1'b0, opSll, d, '0, shamt_t'(i));
			runCycle("shift", 1'b1, 1'b0, opSra, d, '0, shamt_t'(i));
		end
		endTest("shift");

		startTest();
		a = randWord();
		runCycle("compare", 1'b1, 1'b0, opAnd, a, a, '0);
		runCycle("compare", 1'b1, 1'b0, opAnd, a, a ^ 32'h1, '0);
		runCycle("compare", 1'b1, 1'b0, opAnd, a ^ 32'h1, a, '0);
		runCycle("compare", 1'b1, 1'b0, opAnd, a, a ^ 32'h8000_0000, '0);
		runCycle("compare", 1'b1, 1'b0, opAnd, a ^ 32'h8000_0000, a, '0);
		repeat (50) begin
			a = randWord();
			b = randWord();
			runCycle("compare", 1'b1, 1'b0, opSub, a, b, '0);
		end
		endTest("compare");

		startTest();
		a = randWord();
		b = randWord();
		runCycle("stall", 1'b1, 1'b0, opOr, a, b, '0);
		repeat (4) begin
			runCycle("stall", 1'b0, 1'b0, opAdd, randWord(), randWord(), shamt_t'(randWord()));
		end
		runCycle("flush", 1'b1, 1'b1, opAdd, a, b, '0);
		runCycle("flush", 1'b1, 1'b0, opSub, a, b, '0);
		runCycle("flush", 1'b0, 1'b1, opSub, a, b, '0);
		for (int op = 6; op < 32; op++) begin
			a = randWord();
			b = (op == 6) ? a : randWord();
			runCycle("undefOp", 1'b1, 1'b0, aluOp_t'(op), a, b, shamt_t'(op));
		end
		endTest("stallFlush");

		we = 1'b0;
		$display("total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#((testCycles + marginCycles) * clkPeriod);
		$display("timeout: run still going after %0d cycles", testCycles + marginCycles);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/aluStage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage_properties import aluPkg::*; (
	input logic clk,
	input logic arstN,
	input logic we,
	input logic flush,
	input word_t result,
	input logic neq,
	input logic lt
);

	resetZero: assert property (
		@(posedge clk) !arstN |-> (result == '0 && !neq && !lt)
	) else $error("outputs not zero while reset is asserted");

	// flush clears even when we is set.
	flushZero: assert property (
		@(posedge clk) disable iff (!arstN)
		flush |=> (result == '0 && !neq && !lt)
	) else $error("outputs not zero after a flush edge");

	stallHold: assert property (
		@(posedge clk) disable iff (!arstN)
		(!we && !flush) |=> ($stable(result) && $stable(neq) && $stable(lt))
	) else $error("outputs changed during a stall");

endmodule

bind aluStage aluStage_properties props_i (.*);

`default_nettype wire

//--- test/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int periodNs = 20,
	parameter int resetCycles = 10
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial begin
		arstN = 1'b1;
		#1 arstN = 1'b0; // clean falling edge.
		repeat (resetCycles) @(posedge clk);
		#2 arstN = 1'b1; // released off the edge.
	end

endmodule

`default_nettype wire

//--- hdl/aluStage.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage import aluPkg::*; #(
	parameter int dataWidth = wordWidth
) (
	input logic clk,
	input logic arstN,
	input word_t opA,
	input word_t opB,
	input aluOp_t aluOp,
	input shamt_t shiftAmt,
	input logic we,
	input logic flush,
	output word_t result,
	output logic neq,
	output logic lt
);

	logic [dataWidth-1:0] aluResult;
	logic aluNeq;
	logic aluLt;

	aluCore #(
		.dataWidth(dataWidth)
	) core_i (
		.opA(opA),
		.opB(opB),
		.aluOp(aluOp),
		.shiftAmt(shiftAmt),
		.aluResult(aluResult),
		.aluNeq(aluNeq),
		.aluLt(aluLt)
	);

	// one cycle of latency to the outputs.
	stageLatch #(
		.dataWidth(dataWidth)
	) latch_i (
		.clk(clk),
		.arstN(arstN),
		.flush(flush),
		.we(we),
		.aluResult(aluResult),
		.aluNeq(aluNeq),
		.aluLt(aluLt),
		.result(result),
		.neq(neq),
		.lt(lt)
	);

endmodule

`default_nettype wire

//--- hdl/stageLatch.sv
`timescale 1ns/1ps
`default_nettype none

module stageLatch import aluPkg::*; #(
	parameter int dataWidth = wordWidth
) (
	input logic clk,
	input logic arstN,
	input logic flush,
	input logic we,
	input logic [dataWidth-1:0] aluResult,
	input logic aluNeq,
	input logic aluLt,
	output logic [dataWidth-1:0] result,
	output logic neq,
	output logic lt
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			neq <= 1'b0;
			lt <= 1'b0;
		end else if (flush) begin
			result <= '0; // flush beats we.
			neq <= 1'b0;
			lt <= 1'b0;
		end else if (we) begin
			result <= aluResult;
			neq <= aluNeq;
			lt <= aluLt;
		end // otherwise stall.
	end

endmodule

`default_nettype wire

//--- hdl/aluCore.sv
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluPkg::*; #(
	parameter int dataWidth = wordWidth
) (
	input logic [dataWidth-1:0] opA,
	input logic [dataWidth-1:0] opB,
	input aluOp_t aluOp,
	input shamt_t shiftAmt,
	output logic [dataWidth-1:0] aluResult,
	output logic aluNeq,
	output logic aluLt
);

	logic isSub;
	logic [dataWidth-1:0] adderB;
	logic [dataWidth-1:0] sum;
	logic shiftRight;
	logic [dataWidth-1:0] shifted;

	// a - b as a + ~b + 1.
	assign isSub = (aluOp == opSub);
	assign adderB = isSub ? ~opB : opB;

	assign shiftRight = (aluOp == opSra);

	lookaheadAdder #(
		.dataWidth(dataWidth)
	) adder_i (
		.a(opA),
		.b(adderB),
		.cIn(isSub),
		.sum(sum),
		.cOut()
	);

	barrelShifter #(
		.dataWidth(dataWidth)
	) shifter_i (
		.data(opA),
		.shiftAmt(shiftAmt),
		.shiftRight(shiftRight),
		.shifted(shifted)
	);

	// flags follow opA and opB for every opcode.
	sliceComparator #(
		.dataWidth(dataWidth)
	) comparator_i (
		.a(opA),
		.b(opB),
		.neq(aluNeq),
		.lt(aluLt)
	);

	always_comb begin
		case (aluOp)
			opAdd, opSub: aluResult = sum;
			opAnd: aluResult = opA & opB;
			opOr: aluResult = opA | opB;
			opSll, opSra: aluResult = shifted;
			default: aluResult = '0; // undefined opcode.
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/sliceComparator.sv
`timescale 1ns/1ps
`default_nettype none

module sliceComparator import aluPkg::*; #(
	parameter int dataWidth = wordWidth
) (
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	output logic neq,
	output logic lt
);

	localparam int sliceCount = dataWidth / 2;

	// decision so far, entry 0 is before the top slice.
	logic [sliceCount:0] neqChain;
	logic [sliceCount:0] ltChain;

	assign neqChain[0] = 1'b0;
	assign ltChain[0] = 1'b0;

	for (genvar s = 0; s < sliceCount; s++) begin : gSlice
		localparam int base = (sliceCount - 1 - s) * 2; // msb slice first.
		logic [1:0] aSlice;
		logic [1:0] bSlice;
		logic sliceNeq;
		logic sliceLt;
		logic hiEq;

		assign aSlice = a[base +: 2];
		assign bSlice = b[base +: 2];

		assign hiEq = ~(aSlice[1] ^ bSlice[1]);
		assign sliceNeq = |(aSlice ^ bSlice);
		assign sliceLt = (~aSlice[1] & bSlice[1]) | (hiEq & ~aSlice[0] & bSlice[0]);

		// an earlier difference wins.
		assign neqChain[s+1] = neqChain[s] | sliceNeq;
		assign ltChain[s+1] = neqChain[s] ? ltChain[s] : sliceLt;
	end

	assign neq = neqChain[sliceCount];
	assign lt = ltChain[sliceCount];

endmodule

`default_nettype wire

//--- hdl/barrelShifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrelShifter import aluPkg::*; #(
	parameter int dataWidth = wordWidth,
	localparam int levels = $clog2(dataWidth)
) (
	input logic [dataWidth-1:0] data,
	input logic [levels-1:0] shiftAmt,
	input logic shiftRight,
	output logic [dataWidth-1:0] shifted
);

	// level outputs, index 0 is the raw input.
	logic [dataWidth-1:0] stageData [levels+1];

	assign stageData[0] = data;

	// widest shift first: 16, 8, 4, 2, 1 for a 32-bit word.
	for (genvar k = 0; k < levels; k++) begin : gLevel
		localparam int step = 1 << (levels - 1 - k);
		logic [dataWidth-1:0] leftOut;
		logic [dataWidth-1:0] rightOut;
		logic signBit;

		assign signBit = stageData[k][dataWidth-1];

		// zero fill from the bottom.
		assign leftOut = {stageData[k][dataWidth-1-step:0], {step{1'b0}}};

		// sign fill from the top.
		assign rightOut = {{step{signBit}}, stageData[k][dataWidth-1:step]};

		always_comb begin
			if (!shiftAmt[levels-1-k]) begin
				stageData[k+1] = stageData[k]; // level bypassed.
			end else if (shiftRight) begin
				stageData[k+1] = rightOut;
			end else begin
				stageData[k+1] = leftOut;
			end
		end
	end

	assign shifted = stageData[levels];

endmodule

`default_nettype wire

//--- hdl/lookaheadAdder.sv
`timescale 1ns/1ps
`default_nettype none

module lookaheadAdder import aluPkg::*; #(
	parameter int dataWidth = wordWidth
) (
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic cIn,
	output logic [dataWidth-1:0] sum,
	output logic cOut
);

	localparam int blockCount = dataWidth / 8;

	logic [blockCount:0] blockCarry;

	assign blockCarry[0] = cIn;

	for (genvar blk = 0; blk < blockCount; blk++) begin : gBlock
		logic [7:0] gen;
		logic [7:0] prop;
		logic [7:0] carry;
		logic [8:0] genChain;
		logic blockGen;
		logic blockProp;

		assign gen = a[blk*8 +: 8] & b[blk*8 +: 8];
		assign prop = a[blk*8 +: 8] ^ b[blk*8 +: 8];

		// carries inside the block.
		assign carry[0] = blockCarry[blk];
		for (genvar idx = 0; idx < 7; idx++) begin : gCarry
			assign carry[idx+1] = gen[idx] | (prop[idx] & carry[idx]);
		end

		// group generate, independent of the incoming carry.
		assign genChain[0] = 1'b0;
		for (genvar idx = 0; idx < 8; idx++) begin : gGroup
			assign genChain[idx+1] = gen[idx] | (prop[idx] & genChain[idx]);
		end

		assign blockGen = genChain[8];
		assign blockProp = &prop;
		assign blockCarry[blk+1] = blockGen | (blockProp & blockCarry[blk]); // skips the ripple.

		assign sum[blk*8 +: 8] = prop ^ carry;
	end

	assign cOut = blockCarry[blockCount];

endmodule

`default_nettype wire

//--- hdl/aluPkg.sv
`default_nettype none

package aluPkg;

	// datapath width of the processor.
	localparam int wordWidth = 32;
	localparam int shamtWidth = 5;
	localparam int opWidth = 5; // same width as the control field.

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [shamtWidth-1:0] shamt_t;
	typedef logic [opWidth-1:0] aluOp_t;

	localparam aluOp_t opAdd = 5'd0;
	localparam aluOp_t opSub = 5'd1;
	localparam aluOp_t opAnd = 5'd2;
	localparam aluOp_t opOr = 5'd3;
	localparam aluOp_t opSll = 5'd4;
	localparam aluOp_t opSra = 5'd5; // codes above this are undefined.

endpackage

`default_nettype wire
